//--- rtl/mipsPkg.sv
/*
  Shared types and constants for the multicycle MIPS subset core.
  Word addressed bus with whole-word transfers only, no HI/LO.
  Opcodes outside opcode_e decode as no-ops in the ALU.
*/
package mipsPkg;

    localparam int XLEN = 32;                          // Data and address width
    localparam int REG_COUNT = 32;
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'hBFC00000;
    localparam logic [XLEN-1:0] HALT_ADDRESS = 32'h00000000; // PC of zero stops the core
    localparam logic [4:0] V0_INDEX = 5'd2;            // Result register, shown on registerV0

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0] regAddr_t;

    typedef enum logic [5:0] {
        OPCODE_R     = 6'd0,                           // Decoded further by funct
        OPCODE_J     = 6'd2,
        OPCODE_BEQ   = 6'd4,
        OPCODE_BNE   = 6'd5,
        OPCODE_ADDIU = 6'd9,
        OPCODE_SLTI  = 6'd10,
        OPCODE_SLTIU = 6'd11,
        OPCODE_ANDI  = 6'd12,
        OPCODE_ORI   = 6'd13,
        OPCODE_XORI  = 6'd14,
        OPCODE_LUI   = 6'd15,
        OPCODE_LW    = 6'd35,
        OPCODE_SW    = 6'd43
    } opcode_e;

    typedef enum logic [5:0] {
        FUNCT_SLL  = 6'd0,
        FUNCT_SRL  = 6'd2,
        FUNCT_SRA  = 6'd3,
        FUNCT_JR   = 6'd8,
        FUNCT_ADDU = 6'd33,
        FUNCT_SUBU = 6'd35,
        FUNCT_AND  = 6'd36,
        FUNCT_OR   = 6'd37,
        FUNCT_XOR  = 6'd38,
        FUNCT_SLT  = 6'd42,
        FUNCT_SLTU = 6'd43
    } funct_e;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        MEMORY  = 2'd2,
        HALT    = 2'd3
    } cpuState_e;

    typedef struct packed {
        opcode_e  opcode;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        logic [4:0] shamt;
        funct_e   funct;
    } rFormat_t;

    typedef struct packed {
        opcode_e  opcode;
        regAddr_t rs;
        regAddr_t rt;
        logic [15:0] immediate;
    } iFormat_t;

    typedef struct packed {
        opcode_e opcode;
        logic [25:0] target;                           // Word index within the 256 MB region
    } jFormat_t;

    // Same 32 bits, three field layouts
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        jFormat_t j;
    } instr_u;

    typedef struct packed {
        logic     writeEnable;                         // Register write wanted, never for r0
        regAddr_t writeAddr;
        word_t    writeData;
        word_t    memAddr;                             // Effective address for LW/SW
        logic     isLoad;
        logic     isStore;
        logic     takeJump;
        word_t    jumpTarget;
    } execResult_t;

    typedef struct packed {
        logic     enable;
        regAddr_t addr;
        word_t    data;
    } regWrite_t;

endpackage

//--- rtl/aluUnit.sv
/*
  Combinational decode and execute of the latched instruction.
  Shifts by shamt only. Unknown opcodes and functs give no write, no jump.
  Destination writes to r0 are masked here.
*/
`timescale 1ns/1ns

module aluUnit (
    input  mipsPkg::instr_u      instr,
    input  mipsPkg::word_t       pc,
    input  mipsPkg::word_t       rsData,
    input  mipsPkg::word_t       rtData,
    output mipsPkg::execResult_t exec
);

    mipsPkg::word_t signImm;
    mipsPkg::word_t zeroImm;
    mipsPkg::word_t pcPlus4;
    mipsPkg::word_t branchTarget;

    assign signImm = {{16{instr.i.immediate[15]}}, instr.i.immediate};
    assign zeroImm = {16'b0, instr.i.immediate};        // ANDI, ORI, XORI
    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};

    always_comb begin
        exec = '0;
        exec.writeAddr = instr.i.rt;                   // I-type default destination
        exec.memAddr = rsData + signImm;
        exec.jumpTarget = branchTarget;
        case (instr.r.opcode)
            mipsPkg::OPCODE_R: begin
                exec.writeAddr = instr.r.rd;
                exec.writeEnable = 1'b1;
                case (instr.r.funct)
                    mipsPkg::FUNCT_ADDU: exec.writeData = rsData + rtData;
                    mipsPkg::FUNCT_SUBU: exec.writeData = rsData - rtData;
                    mipsPkg::FUNCT_AND:  exec.writeData = rsData & rtData;
                    mipsPkg::FUNCT_OR:   exec.writeData = rsData | rtData;
                    mipsPkg::FUNCT_XOR:  exec.writeData = rsData ^ rtData;
                    mipsPkg::FUNCT_SLT:  exec.writeData = {31'b0, $signed(rsData) < $signed(rtData)};
                    mipsPkg::FUNCT_SLTU: exec.writeData = {31'b0, rsData < rtData};
                    mipsPkg::FUNCT_SLL:  exec.writeData = rtData << instr.r.shamt;
                    mipsPkg::FUNCT_SRL:  exec.writeData = rtData >> instr.r.shamt;
                    mipsPkg::FUNCT_SRA:  exec.writeData = $signed(rtData) >>> instr.r.shamt;
                    mipsPkg::FUNCT_JR: begin
                        exec.writeEnable = 1'b0;
                        exec.takeJump = 1'b1;
                        exec.jumpTarget = rsData;      // Zero here means halt
                    end
                    default: exec.writeEnable = 1'b0; // No-op
                endcase
            end
            mipsPkg::OPCODE_ADDIU: begin
                exec.writeEnable = 1'b1;
                exec.writeData = rsData + signImm;
            end
            mipsPkg::OPCODE_SLTI: begin
                exec.writeEnable = 1'b1;
                exec.writeData = {31'b0, $signed(rsData) < $signed(signImm)};
            end
            mipsPkg::OPCODE_SLTIU: begin
                exec.writeEnable = 1'b1;
                exec.writeData = {31'b0, rsData < signImm}; // Sign-extended, compared unsigned
            end
            mipsPkg::OPCODE_ANDI: begin
                exec.writeEnable = 1'b1;
                exec.writeData = rsData & zeroImm;
            end
            mipsPkg::OPCODE_ORI: begin
                exec.writeEnable = 1'b1;
                exec.writeData = rsData | zeroImm;
            end
            mipsPkg::OPCODE_XORI: begin
                exec.writeEnable = 1'b1;
                exec.writeData = rsData ^ zeroImm;
            end
            mipsPkg::OPCODE_LUI: begin
                exec.writeEnable = 1'b1;
                exec.writeData = {instr.i.immediate, 16'b0};
            end
            mipsPkg::OPCODE_LW: begin
                exec.writeEnable = 1'b1;               // Data arrives in MEMORY
                exec.isLoad = 1'b1;
            end
            mipsPkg::OPCODE_SW:  exec.isStore = 1'b1;
            mipsPkg::OPCODE_BEQ: exec.takeJump = (rsData == rtData);
            mipsPkg::OPCODE_BNE: exec.takeJump = (rsData != rtData);
            mipsPkg::OPCODE_J: begin
                exec.takeJump = 1'b1;
                exec.jumpTarget = {pcPlus4[31:28], instr.j.target, 2'b00};
            end
            default: ;                                 // Unknown opcode, no-op
        endcase
        if (exec.writeAddr == '0) begin
            exec.writeEnable = 1'b0;                   // r0 stays zero
        end
    end

endmodule

//--- rtl/regFile.sv
/*
  32-entry register file, two combinational reads, one write port.
  r0 reads zero and drops writes. All writable entries clear on reset.
*/
`timescale 1ns/1ns

module regFile (
    input  logic               clk,
    input  logic               reset,
    input  mipsPkg::regAddr_t  rsAddr,
    input  mipsPkg::regAddr_t  rtAddr,
    output mipsPkg::word_t     rsData,
    output mipsPkg::word_t     rtData,
    input  mipsPkg::regWrite_t regWrite,
    output mipsPkg::word_t     registerV0
);

    mipsPkg::word_t regs [mipsPkg::REG_COUNT-1:1];    // No storage behind r0

    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];
    assign registerV0 = regs[mipsPkg::V0_INDEX];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < mipsPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite.enable && (regWrite.addr != '0)) begin
            regs[regWrite.addr] <= regWrite.data;
        end
    end

endmodule

//--- rtl/programCounter.sv
/*
  Program counter, starts at the reset vector.
  Moves only on pcAdvance, to the jump target or to PC + 4.
*/
`timescale 1ns/1ns

module programCounter (
    input  logic           clk,
    input  logic           reset,
    input  logic           pcAdvance,
    input  logic           takeJump,
    input  mipsPkg::word_t jumpTarget,
    output mipsPkg::word_t pc
);

    mipsPkg::word_t pcNext;

    // No delay slot, a taken jump applies to the very next fetch
    assign pcNext = takeJump ? jumpTarget : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mipsPkg::RESET_VECTOR;
        end else if (pcAdvance) begin
            pc <= pcNext;                              // Visible in the cycle after retire
        end
    end

endmodule

//--- rtl/cpuControl.sv
/*
  Sequencer for FETCH, EXECUTE, MEMORY and HALT.
  Bus requests are registered and held until waitRequest is low.
  Address comes from PC, or from the effective address in MEMORY.
  Only whole-word stores, so byteEnable is all ones with write.
*/
`timescale 1ns/1ns

module cpuControl (
    input  logic                 clk,
    input  logic                 reset,
    input  mipsPkg::word_t       pc,
    input  mipsPkg::word_t       readData,
    input  logic                 waitRequest,
    input  mipsPkg::execResult_t exec,
    input  mipsPkg::word_t       storeData,        // rt value for SW
    output mipsPkg::instr_u      instr,
    output mipsPkg::regWrite_t   regWrite,
    output logic                 pcAdvance,
    output logic                 active,
    output mipsPkg::word_t       address,
    output logic                 read,
    output logic                 write,
    output mipsPkg::word_t       writeData,
    output logic [3:0]           byteEnable
);

    mipsPkg::cpuState_e state;
    logic memOp;                                       // LW or SW in the instruction register
    logic haltNext;                                    // Retiring jump lands on zero
    logic fetchDone;
    logic memDone;

    assign memOp = exec.isLoad | exec.isStore;
    assign haltNext = exec.takeJump && (exec.jumpTarget == mipsPkg::HALT_ADDRESS);
    assign fetchDone = (state == mipsPkg::FETCH) && read && !waitRequest;
    assign memDone = (state == mipsPkg::MEMORY) && !waitRequest;

    // Bus side, all derived from held state so stalls keep it steady
    assign address = (state == mipsPkg::MEMORY) ? exec.memAddr : pc;
    assign writeData = storeData;
    assign byteEnable = {4{write}};

    // Retire: ALU ops in EXECUTE, LW/SW once the transfer completes
    assign pcAdvance = ((state == mipsPkg::EXECUTE) && !memOp) || memDone;

    always_comb begin
        regWrite.addr = exec.writeAddr;
        regWrite.data = exec.writeData;
        regWrite.enable = 1'b0;
        if (state == mipsPkg::EXECUTE) begin
            regWrite.enable = exec.writeEnable && !exec.isLoad;
        end else if (memDone) begin
            regWrite.enable = exec.writeEnable && exec.isLoad;
            regWrite.data = readData;                  // Load data straight off the bus
        end
    end

    // Instruction register
    always_ff @(posedge clk) begin
        if (fetchDone) begin
            instr <= readData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mipsPkg::FETCH;
            read <= 1'b0;
            write <= 1'b0;
            active <= 1'b1;
        end else begin
            case (state)
                mipsPkg::FETCH: begin
                    if (!read) begin
                        read <= 1'b1;                  // First fetch after reset
                    end else if (!waitRequest) begin
                        read <= 1'b0;
                        state <= mipsPkg::EXECUTE;
                    end
                end
                mipsPkg::EXECUTE: begin
                    if (memOp) begin
                        read <= exec.isLoad;
                        write <= exec.isStore;
                        state <= mipsPkg::MEMORY;
                    end else if (haltNext) begin
                        active <= 1'b0;                // Bus stays idle from here
                        state <= mipsPkg::HALT;
                    end else begin
                        read <= 1'b1;                  // Next fetch, PC updates on this edge
                        state <= mipsPkg::FETCH;
                    end
                end
                mipsPkg::MEMORY: begin
                    if (!waitRequest) begin
                        read <= 1'b1;                  // Straight into the next fetch
                        write <= 1'b0;
                        state <= mipsPkg::FETCH;
                    end
                end
                mipsPkg::HALT: begin
                    read <= 1'b0;
                    write <= 1'b0;
                    active <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- rtl/mipsCpu.sv
/*
  Multicycle MIPS subset core, Avalon-style bus master.
  One instruction in flight, no branch delay slot.
  Jump or branch to address zero halts; only reset restarts.
*/
`timescale 1ns/1ns

module mipsCpu (
    input  logic           clk,
    input  logic           reset,
    output logic           active,
    output mipsPkg::word_t registerV0,
    output mipsPkg::word_t address,
    output logic           write,
    output logic           read,
    input  logic           waitRequest,
    output mipsPkg::word_t writeData,
    output logic [3:0]     byteEnable,
    input  mipsPkg::word_t readData
);

    mipsPkg::word_t       pc;
    mipsPkg::word_t       rsData;
    mipsPkg::word_t       rtData;
    mipsPkg::instr_u      instr;                       // Latched instruction word
    mipsPkg::execResult_t exec;
    mipsPkg::regWrite_t   regWrite;
    logic                 pcAdvance;                   // One cycle per retired instruction

    cpuControl control (
        .clk(clk), .reset(reset), .pc(pc), .readData(readData),
        .waitRequest(waitRequest), .exec(exec), .storeData(rtData),
        .instr(instr), .regWrite(regWrite), .pcAdvance(pcAdvance),
        .active(active), .address(address), .read(read), .write(write),
        .writeData(writeData), .byteEnable(byteEnable)
    );

    programCounter pcReg (
        .clk(clk), .reset(reset), .pcAdvance(pcAdvance),
        .takeJump(exec.takeJump), .jumpTarget(exec.jumpTarget), .pc(pc)
    );

    regFile regs (
        .clk(clk), .reset(reset),
        .rsAddr(instr.r.rs), .rtAddr(instr.r.rt),   // Same bit slots in R and I views
        .rsData(rsData), .rtData(rtData),
        .regWrite(regWrite), .registerV0(registerV0)
    );

    aluUnit alu (
        .instr(instr), .pc(pc), .rsData(rsData), .rtData(rtData), .exec(exec)
    );

endmodule

//--- bench/mipsCpu_props.sv
/*
  Bus and halt properties for mipsCpu, attached by bind.
  Assumes requests are held until a cycle with waitRequest low.
*/
`timescale 1ns/1ns

module mipsCpuProps (
    input logic           clk,
    input logic           reset,
    input logic           active,
    input logic           read,
    input logic           write,
    input logic           waitRequest,
    input mipsPkg::word_t address,
    input mipsPkg::word_t writeData,
    input logic [3:0]     byteEnable
);

    int failures = 0;                                  // Read by the testbench at the end

    noReadWithWrite: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            failures++;
            $error("read and write high in the same cycle");
        end

    // Stalled request keeps every bus output
    holdOnStall: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitRequest |=> $stable(address) && $stable(writeData)
            && $stable(byteEnable) && $stable(read) && $stable(write))
        else begin
            failures++;
            $error("bus outputs changed during a stall");
        end

    fullWordStore: assert property (@(posedge clk) disable iff (reset)
        write |-> byteEnable == 4'hF)
        else begin
            failures++;
            $error("byteEnable not all ones on a write");
        end

    alignedRead: assert property (@(posedge clk) disable iff (reset)
        read |-> address[1:0] == 2'b00)
        else begin
            failures++;
            $error("read address not word aligned");
        end

    idleInReset: assert property (@(posedge clk) reset |=> !read && !write)
        else begin
            failures++;
            $error("bus request during reset");
        end

    // Halt is final until reset
    staysHalted: assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else begin
            failures++;
            $error("active rose again after the halt");
        end

    quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            failures++;
            $error("bus request while halted");
        end

endmodule

//--- bench/avalonMemory.sv
/*
  Behavioral Avalon-style word memory for the core testbench.
  Program image from the reset vector, data words at 0x000 to 0x1FF.
  waitRequest is random with at most MAX_STALLS stalls in a row.
  Outputs change DRIVE_DELAY after the rising edge. Whole words only.
*/
`timescale 1ns/1ns

module avalonMemory (
    input  logic           clk,
    input  logic           reset,
    input  mipsPkg::word_t address,
    input  logic           read,
    input  logic           write,
    input  mipsPkg::word_t writeData,
    output logic           waitRequest,
    output mipsPkg::word_t readData,
    output int             errorCount
);

    localparam int PROG_WORDS = 64;
    localparam int DATA_WORDS = 128;
    localparam int MAX_STALLS = 3;
    localparam int DRIVE_DELAY = 2;
    localparam mipsPkg::word_t PROG_BYTES = 32'h100;
    localparam mipsPkg::word_t DATA_BYTES = 32'h200;
    localparam mipsPkg::word_t POISON_A = 32'(28 * 4);    // Skipped by the taken BEQ
    localparam mipsPkg::word_t POISON_B = 32'(32 * 4);    // Skipped by the J
    localparam mipsPkg::word_t STORE_ADDRESS = 32'h00000100;
    localparam mipsPkg::word_t STORE_VALUE = 32'h8765431C; // r10 = A + (-5)

    mipsPkg::word_t prog [PROG_WORDS];
    mipsPkg::word_t data [DATA_WORDS];
    mipsPkg::word_t progOffset;
    int seed = 37995;
    int stallRun = 0;                                  // Stalled cycles of the current request
    int errors = 0;

    assign progOffset = address - mipsPkg::RESET_VECTOR;
    assign errorCount = errors;

    // Small assemblers for the program image
    function automatic mipsPkg::word_t rOp(int rs, int rt, int rd, int shamt,
                                           mipsPkg::funct_e funct);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic mipsPkg::word_t iOp(mipsPkg::opcode_e op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic mipsPkg::word_t jOp(int word);
        mipsPkg::word_t target;
        target = mipsPkg::RESET_VECTOR + 32'(word * 4);
        return {mipsPkg::OPCODE_J, target[27:2]};
    endfunction

    initial begin
        waitRequest = 1'b0;
        readData = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = {6'h3F, 26'(i)};                 // Unknown opcode, a no-op
        end
        prog[0] = iOp(mipsPkg::OPCODE_LUI, 0, 8, 'h8765);
        prog[1] = iOp(mipsPkg::OPCODE_ORI, 8, 8, 'h4321);    // r8 = A = 87654321
        prog[2] = iOp(mipsPkg::OPCODE_ADDIU, 0, 9, -5);      // r9 = B = FFFFFFFB
        prog[3] = rOp(8, 9, 10, 0, mipsPkg::FUNCT_ADDU);     // 8765431C
        prog[4] = rOp(9, 8, 11, 0, mipsPkg::FUNCT_SUBU);     // 789ABCDA
        prog[5] = rOp(10, 11, 12, 0, mipsPkg::FUNCT_AND);    // 00000018
        prog[6] = rOp(10, 11, 13, 0, mipsPkg::FUNCT_OR);     // FFFFFFDE
        prog[7] = rOp(12, 13, 2, 0, mipsPkg::FUNCT_XOR);     // r2 = FFFFFFC6
        prog[8] = rOp(0, 2, 14, 4, mipsPkg::FUNCT_SLL);      // FFFFFC60
        prog[9] = rOp(0, 8, 15, 8, mipsPkg::FUNCT_SRL);      // 00876543
        prog[10] = rOp(0, 8, 16, 8, mipsPkg::FUNCT_SRA);     // FF876543
        prog[11] = rOp(14, 15, 2, 0, mipsPkg::FUNCT_XOR);    // FF789923
        prog[12] = rOp(2, 16, 2, 0, mipsPkg::FUNCT_XOR);     // 00FFFC60
        // Compares mix signs, so signed and unsigned answers differ
        prog[13] = rOp(9, 15, 17, 0, mipsPkg::FUNCT_SLT);    // 1
        prog[14] = rOp(9, 15, 18, 0, mipsPkg::FUNCT_SLTU);   // 0
        prog[15] = iOp(mipsPkg::OPCODE_SLTI, 15, 19, -6);    // 0
        prog[16] = iOp(mipsPkg::OPCODE_SLTIU, 15, 20, -4);   // 1
        prog[17] = rOp(2, 17, 2, 0, mipsPkg::FUNCT_XOR);     // Flags folded one bit apart
        prog[18] = rOp(2, 2, 2, 0, mipsPkg::FUNCT_ADDU);
        prog[19] = rOp(2, 18, 2, 0, mipsPkg::FUNCT_XOR);
        prog[20] = rOp(2, 2, 2, 0, mipsPkg::FUNCT_ADDU);
        prog[21] = rOp(2, 19, 2, 0, mipsPkg::FUNCT_XOR);
        prog[22] = rOp(2, 2, 2, 0, mipsPkg::FUNCT_ADDU);
        prog[23] = rOp(2, 20, 2, 0, mipsPkg::FUNCT_XOR);     // r2 = 07FFE309
        prog[24] = iOp(mipsPkg::OPCODE_SW, 0, 10, 'h100);
        prog[25] = iOp(mipsPkg::OPCODE_LW, 0, 21, 'h100);
        prog[26] = rOp(2, 21, 2, 0, mipsPkg::FUNCT_ADDU);    // 8F652625
        prog[27] = iOp(mipsPkg::OPCODE_BEQ, 17, 20, 1);      // Taken
        prog[28] = iOp(mipsPkg::OPCODE_ADDIU, 2, 2, 'h100);  // Poisoned
        prog[29] = iOp(mipsPkg::OPCODE_BNE, 17, 20, 1);      // Not taken
        prog[30] = iOp(mipsPkg::OPCODE_ADDIU, 2, 2, 'h10);
        prog[31] = jOp(33);
        prog[32] = iOp(mipsPkg::OPCODE_ADDIU, 2, 2, 'h200);  // Poisoned
        prog[33] = iOp(mipsPkg::OPCODE_ADDIU, 2, 2, 1);      // r2 = 8F652636
        prog[34] = rOp(0, 0, 0, 0, mipsPkg::FUNCT_JR);       // Halt
        forever begin
            @(posedge clk);
            if (reset) begin
                stallRun = 0;
                for (int i = 0; i < DATA_WORDS; i++) begin
                    data[i] = 32'hA5A50000 | 32'(i * 4);  // Pattern follows the address
                end
            end else begin
                if (write && !waitRequest) begin        // Store completes on this edge
                    if (address !== STORE_ADDRESS) begin
                        $display("ERR %0t address expected %h actual %h",
                                 $time, STORE_ADDRESS, address);
                        errors++;
                    end
                    if (writeData !== STORE_VALUE) begin
                        $display("ERR %0t writeData expected %h actual %h",
                                 $time, STORE_VALUE, writeData);
                        errors++;
                    end
                    if (address < DATA_BYTES) begin
                        data[address[8:2]] = writeData;
                    end
                end
                if (read && !waitRequest
                        && (progOffset == POISON_A || progOffset == POISON_B)) begin
                    $display("Fetch from skipped address %h at %0t", address, $time);
                    errors++;
                end
                stallRun = ((read || write) && waitRequest) ? stallRun + 1 : 0;
            end
            #DRIVE_DELAY;
            waitRequest = !reset && (stallRun < MAX_STALLS) && (($random(seed) % 2) != 0);
            if (address < DATA_BYTES) begin
                readData = data[address[8:2]];
            end else if (progOffset < PROG_BYTES) begin
                readData = prog[progOffset[7:2]];
            end else begin
                readData = ~address;                   // Unmapped
            end
        end
    end

endmodule

//--- bench/mipsCpuTb.sv
/*
  Testbench for mipsCpu running the fixed program held in avalonMemory.
  The expected registerV0 is worked out by hand from the instruction rules.
  Bus protocol and halt rules are checked by the bound property module.
*/
`timescale 1ns/1ns

module mipsCpuTb;

    localparam int PERIOD = 20;
    localparam int HOLD = 2;                           // Drive delay after the rising edge
    localparam int RESET_CYCLES = 2;
    localparam int PROGRAM_WORDS = 35;
    localparam int WORST_CPI = 9;                      // Fetch 1+3, execute 1, memory 1+3
    localparam int TIMEOUT = (2 * PROGRAM_WORDS * WORST_CPI + RESET_CYCLES) * PERIOD;
    localparam int HALT_SETTLE = 5;                    // Cycles watched after the halt
    // ALU block leaves 07FFE309, the load adds 8765431C, branch path adds 10 and 1
    localparam mipsPkg::word_t EXPECTED_V0 = 32'h8F652636;

    logic           clk;
    logic           reset;
    logic           active;
    logic           read;
    logic           write;
    logic           waitRequest;
    logic [3:0]     byteEnable;
    mipsPkg::word_t registerV0;
    mipsPkg::word_t address;
    mipsPkg::word_t writeData;
    mipsPkg::word_t readData;
    int             memErrors;
    int             checkErrors;
    int             totalErrors;

    mipsCpu DUT (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitRequest(waitRequest),
        .writeData(writeData), .byteEnable(byteEnable), .readData(readData)
    );

    avalonMemory memory (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .writeData(writeData), .waitRequest(waitRequest), .readData(readData),
        .errorCount(memErrors)
    );

    bind mipsCpu mipsCpuProps props (
        .clk(clk), .reset(reset), .active(active), .read(read), .write(write),
        .waitRequest(waitRequest), .address(address), .writeData(writeData),
        .byteEnable(byteEnable)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Timeout: the processor did not halt within %0d ns", TIMEOUT);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        checkErrors = 0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #HOLD;
        reset = 1'b0;
        wait (active == 1'b0);                         // JR to r0 reached
        repeat (HALT_SETTLE) @(posedge clk);
        #HOLD;
        finalV0: assert (registerV0 === EXPECTED_V0) else begin
            $display("ERR %0t registerV0 expected %h actual %h",
                     $time, EXPECTED_V0, registerV0);
            checkErrors++;
        end
        idleBus: assert (!read && !write && !active) else begin
            $display("Bus or active flag not idle after the halt at %0t", $time);
            checkErrors++;
        end
        totalErrors = checkErrors + memErrors + DUT.props.failures;
        $display("Errors %0d (final checks %0d, memory %0d, assertions %0d)",
                 totalErrors, checkErrors, memErrors, DUT.props.failures);
        if (totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/mipsPkg.sv
rtl/aluUnit.sv
rtl/regFile.sv
rtl/programCounter.sv
rtl/cpuControl.sv
rtl/mipsCpu.sv
bench/mipsCpu_props.sv
bench/avalonMemory.sv
bench/mipsCpuTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" \
    && verilator --binary --assert --timing --top-module mipsCpuTb -f compile.f \
    && ./obj_dir/VmipsCpuTb | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
